/* source/aes_pkg.sv */
`default_nettype none

package aes_pkg;

    typedef logic [127:0] block_t;     // FIPS-197 column-major, byte 0 in the top bits
    typedef logic [127:0] key_t;
    typedef logic [31:0]  word_t;
    typedef logic [3:0]   round_idx_t; // Round key index 0..10

    localparam int NUM_ROUNDS   = 10;
    localparam int NUM_KEYS     = 11;
    localparam int PIPE_LATENCY = 11;  // Stage 0 plus ten rounds

    // Forward S-box
    localparam logic [7:0] SBOX [0:255] = '{
        8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
        8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
        8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
        8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
        8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
        8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
        8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
        8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
        8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
        8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
        8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
        8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
        8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
        8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
        8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
        8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
        8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
        8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
        8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
        8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
        8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
        8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
        8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
        8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
        8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
        8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
        8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
        8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
        8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
        8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
        8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
        8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
    };

    // Round constants for round keys 1..10
    localparam logic [7:0] RCON [0:9] = '{
        8'h01, 8'h02, 8'h04, 8'h08, 8'h10, 8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
    };

    function automatic word_t sub_word(input word_t w);
        return {SBOX[w[31:24]], SBOX[w[23:16]], SBOX[w[15:8]], SBOX[w[7:0]]};
    endfunction

    function automatic word_t rot_word(input word_t w);
        return {w[23:0], w[31:24]};
    endfunction

    function automatic logic [7:0] xtime(input logic [7:0] b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic block_t sub_bytes(input block_t s);
        block_t r;
        for (int i = 0; i < 16; i++) begin
            r[8*i +: 8] = SBOX[s[8*i +: 8]];
        end
        return r;
    endfunction

    // Row r moves left by r columns
    function automatic block_t shift_rows(input block_t s);
        block_t r;
        for (int c = 0; c < 4; c++) begin
            for (int row = 0; row < 4; row++) begin
                r[127 - 8*(4*c + row) -: 8] = s[127 - 8*(4*((c + row) % 4) + row) -: 8];
            end
        end
        return r;
    endfunction

    function automatic block_t mix_columns(input block_t s);
        block_t     r;
        logic [7:0] a0;
        logic [7:0] a1;
        logic [7:0] a2;
        logic [7:0] a3;
        for (int c = 0; c < 4; c++) begin
            {a0, a1, a2, a3} = s[127 - 32*c -: 32];
            r[127 - 32*c -: 32] = {
                xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
                a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
                a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
                xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)
            };
        end
        return r;
    endfunction

endpackage

`default_nettype wire

/* source/round_key_if.sv */
`timescale 1ns/1ps
`default_nettype none

// Round keys from the key schedule into the key register file
interface round_key_if;

    logic                wr;    // One key per strobe
    aes_pkg::round_idx_t idx;
    aes_pkg::key_t       key;
    logic                done;  // Comes with the write of index 10

    modport producer (
        output wr,
        output idx,
        output key,
        output done
    );

    modport buffer (
        input wr,
        input idx,
        input key,
        input done
    );

endinterface

`default_nettype wire

/* source/key_expander.sv */
`timescale 1ns/1ps
`default_nettype none

module key_expander (
    input  wire logic          clk,
    input  wire logic          rst,
    input  wire logic          key_load,
    input  wire aes_pkg::key_t key_in,
    round_key_if.producer      kif
);

    aes_pkg::key_t       cur_key;    // Round key currently on the bus
    aes_pkg::round_idx_t round_cnt;
    logic                wr_q;
    logic                done_q;
    logic                last_idx;
    logic [7:0]          rcon_byte;
    aes_pkg::word_t      temp;
    aes_pkg::word_t      n0;
    aes_pkg::word_t      n1;
    aes_pkg::word_t      n2;
    aes_pkg::word_t      n3;

    assign last_idx  = (round_cnt == aes_pkg::round_idx_t'(aes_pkg::NUM_ROUNDS));
    assign rcon_byte = last_idx ? 8'h00 : aes_pkg::RCON[round_cnt];

    // Next round key from the last word of the current one
    assign temp = aes_pkg::sub_word(aes_pkg::rot_word(cur_key[31:0])) ^ {rcon_byte, 24'h000000};
    assign n0   = cur_key[127:96] ^ temp;
    assign n1   = cur_key[95:64] ^ n0;
    assign n2   = cur_key[63:32] ^ n1;
    assign n3   = cur_key[31:0] ^ n2;

    always_ff @(posedge clk) begin
        if (!rst) begin
            wr_q      <= 1'b0;
            done_q    <= 1'b0;
            round_cnt <= '0;
        end else if (key_load) begin   // Also restarts a schedule in progress
            wr_q      <= 1'b1;
            done_q    <= 1'b0;
            round_cnt <= '0;
        end else if (wr_q && !last_idx) begin
            round_cnt <= round_cnt + 4'd1;
            done_q    <= (round_cnt == aes_pkg::round_idx_t'(aes_pkg::NUM_ROUNDS - 1));
        end else begin
            wr_q   <= 1'b0;
            done_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (key_load) begin
            cur_key <= key_in;             // Round key 0 is the cipher key
        end else if (wr_q && !last_idx) begin
            cur_key <= {n0, n1, n2, n3};
        end
    end

    assign kif.wr   = wr_q;
    assign kif.idx  = round_cnt;
    assign kif.key  = cur_key;
    assign kif.done = done_q;

    // Index 10 is the last entry and the only write flagged done
    a_idx_range: assert property (
        @(posedge clk) disable iff (!rst)
        kif.wr |-> (kif.idx <= aes_pkg::round_idx_t'(aes_pkg::NUM_ROUNDS))
                   && (kif.done == (kif.idx == aes_pkg::round_idx_t'(aes_pkg::NUM_ROUNDS)))
    );

endmodule

`default_nettype wire

/* source/round_key_store.sv */
`timescale 1ns/1ps
`default_nettype none

module round_key_store (
    input  wire logic     clk,
    input  wire logic     rst,
    input  wire logic     key_load,
    round_key_if.buffer   kif,
    output aes_pkg::key_t round_keys [aes_pkg::NUM_KEYS],
    output logic          keys_ready
);

    always_ff @(posedge clk) begin
        if (kif.wr) begin
            round_keys[kif.idx] <= kif.key;
        end
    end

    // Cleared as soon as a new key is loaded, set once index 10 is held
    always_ff @(posedge clk) begin
        if (!rst) begin
            keys_ready <= 1'b0;
        end else if (key_load) begin
            keys_ready <= 1'b0;
        end else if (kif.done) begin
            keys_ready <= 1'b1;
        end
    end

    // The pipeline only reads keys that are stable
    a_no_write_when_ready: assert property (
        @(posedge clk) disable iff (!rst)
        kif.wr |-> !keys_ready
    );

endmodule

`default_nettype wire

/* source/cipher_round.sv */
`timescale 1ns/1ps
`default_nettype none

module cipher_round #(
    parameter bit final_round = 1'b0   // Round 10 has no MixColumns
) (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire aes_pkg::block_t state_in,
    input  wire aes_pkg::key_t   round_key,
    output aes_pkg::block_t      state_out
);

    aes_pkg::block_t shifted;
    aes_pkg::block_t mixed;

    assign shifted = aes_pkg::shift_rows(aes_pkg::sub_bytes(state_in));

    generate
        if (final_round) begin : g_final
            assign mixed = shifted;
        end else begin : g_mix
            assign mixed = aes_pkg::mix_columns(shifted);
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (!rst) begin
            state_out <= '0;
        end else begin
            state_out <= mixed ^ round_key;   // AddRoundKey
        end
    end

endmodule

`default_nettype wire

/* source/encrypt_pipeline.sv */
`timescale 1ns/1ps
`default_nettype none

module encrypt_pipeline (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire aes_pkg::key_t   round_keys [aes_pkg::NUM_KEYS],
    input  wire logic            keys_ready,
    input  wire logic            in_valid,
    input  wire aes_pkg::block_t data_in,
    output logic                 out_valid,
    output aes_pkg::block_t      data_out
);

    logic                             accept;
    logic [aes_pkg::PIPE_LATENCY-1:0] valid_pipe;   // Bit n follows the block in stage n
    aes_pkg::block_t                  stage0;
    wire aes_pkg::block_t             stage [aes_pkg::NUM_KEYS];

    // Blocks offered before the schedule is complete are dropped
    assign accept = in_valid && keys_ready;

    always_ff @(posedge clk) begin
        if (!rst) begin
            valid_pipe <= '0;
        end else begin
            valid_pipe <= {valid_pipe[aes_pkg::PIPE_LATENCY-2:0], accept};
        end
    end

    // Initial AddRoundKey
    always_ff @(posedge clk) begin
        if (!rst) begin
            stage0 <= '0;
        end else begin
            stage0 <= data_in ^ round_keys[0];
        end
    end

    assign stage[0] = stage0;

    genvar r;
    generate
        for (r = 1; r < aes_pkg::NUM_KEYS; r++) begin : g_round
            cipher_round #(
                .final_round (r == aes_pkg::NUM_ROUNDS)
            ) u_round (
                .clk       (clk),
                .rst       (rst),
                .state_in  (stage[r-1]),
                .round_key (round_keys[r]),
                .state_out (stage[r])
            );
        end
    endgenerate

    assign out_valid = valid_pipe[aes_pkg::PIPE_LATENCY-1];
    assign data_out  = stage[aes_pkg::NUM_ROUNDS];

    // Catches a round key that was never written reaching the output
    a_out_known: assert property (
        @(posedge clk) disable iff (!rst)
        out_valid |-> !$isunknown(data_out)
    );

endmodule

`default_nettype wire

/* source/aes_enc_top.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_enc_top (
    input  wire logic            clk,
    input  wire logic            rst,
    input  wire logic            key_load,
    input  wire aes_pkg::key_t   key_in,
    output wire logic            keys_ready,
    input  wire logic            in_valid,
    input  wire aes_pkg::block_t data_in,
    output wire logic            out_valid,
    output wire aes_pkg::block_t data_out
);

    round_key_if kif ();

    wire aes_pkg::key_t round_keys [aes_pkg::NUM_KEYS];

    key_expander u_key_expander (
        .clk      (clk),
        .rst      (rst),
        .key_load (key_load),
        .key_in   (key_in),
        .kif      (kif.producer)
    );

    // Store sees key_load too so keys_ready drops right away
    round_key_store u_round_key_store (
        .clk        (clk),
        .rst        (rst),
        .key_load   (key_load),
        .kif        (kif.buffer),
        .round_keys (round_keys),
        .keys_ready (keys_ready)
    );

    encrypt_pipeline u_encrypt_pipeline (
        .clk        (clk),
        .rst        (rst),
        .round_keys (round_keys),
        .keys_ready (keys_ready),
        .in_valid   (in_valid),
        .data_in    (data_in),
        .out_valid  (out_valid),
        .data_out   (data_out)
    );

endmodule

`default_nettype wire

/* bench/aes_enc_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module aes_enc_tb;

    localparam int KEY_DELAY      = 12;                 // key_load to keys_ready
    localparam int PIPE_DELAY     = 11;                 // in_valid to out_valid
    localparam int DROP_WATCH     = 1 + PIPE_DELAY + 2; // Dropped block is offered one cycle in
    localparam int NUM_ROWS       = 10;
    localparam int TIMEOUT_CYCLES = NUM_ROWS * (KEY_DELAY + PIPE_DELAY + 16) + 50;

    localparam aes_pkg::key_t KEY_A = 128'h000102030405060708090a0b0c0d0e0f;
    localparam aes_pkg::key_t KEY_B = 128'h2b7e151628aed2a6abf7158809cf4f3c;

    typedef enum logic [1:0] {LOAD_KEY, SINGLE, BURST, DROPPED} mode_t;

    typedef struct packed {
        mode_t           mode;
        aes_pkg::key_t   key;
        aes_pkg::block_t pt;
        aes_pkg::block_t ct;
    } vector_t;

    logic            clk;
    logic            rst;
    logic            key_load;
    aes_pkg::key_t   key_in;
    logic            keys_ready;
    logic            in_valid;
    aes_pkg::block_t data_in;
    logic            out_valid;
    aes_pkg::block_t data_out;

    vector_t vectors [NUM_ROWS];
    int      err_cnt   = 0;
    int      pass_cnt  = 0;
    int      fail_cnt  = 0;
    int      cycle_cnt = 0;

    aes_enc_top DUT (
        .clk        (clk),
        .rst        (rst),
        .key_load   (key_load),
        .key_in     (key_in),
        .keys_ready (keys_ready),
        .in_valid   (in_valid),
        .data_in    (data_in),
        .out_valid  (out_valid),
        .data_out   (data_out)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Hard limit on the whole run
    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation FAILED");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clk);
        #2;
    endtask

    task automatic check_block(input string name, input aes_pkg::block_t got,
                               input aes_pkg::block_t exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s: expected %032h, got %032h", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("ERROR t=%0t %s: expected %b, got %b", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic check_latency(input string name, input int got, input int exp);
        if (got != exp) begin
            $display("ERROR t=%0t %s: expected %0d cycles, got %0d", $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic report_failure(input string msg);
        $display("Failure at t=%0t: %s", $time, msg);
        err_cnt++;
    endtask

    task automatic close_test(input int row, input int start_errs);
        if (err_cnt == start_errs) begin
            pass_cnt++;
            $display("Test %0d (%s) passed", row, vectors[row].mode.name());
        end else begin
            fail_cnt++;
            $display("Test %0d (%s) failed", row, vectors[row].mode.name());
        end
    endtask

    // Loads a key; with offer set a block is presented before the keys are ready
    task automatic load_key(input int row, input bit offer);
        int   lat;
        int   ready_lat;
        int   start_errs;
        logic seen_valid;
        bit   watching;
        start_errs = err_cnt;
        key_load   = 1'b1;
        key_in     = vectors[row].key;
        next_cycle();
        lat        = 1;
        key_load   = 1'b0;
        if (offer) begin
            in_valid = 1'b1;
            data_in  = vectors[row].pt;
        end
        check_flag("keys_ready", keys_ready, 1'b0);
        ready_lat  = 0;
        seen_valid = 1'b0;
        watching   = 1'b1;
        while (watching) begin
            next_cycle();
            lat++;
            in_valid = 1'b0;
            if (out_valid) seen_valid = 1'b1;
            if (keys_ready && ready_lat == 0) ready_lat = lat;
            watching = (lat < KEY_DELAY + 4) && (ready_lat == 0 || (offer && lat < DROP_WATCH));
        end
        if (ready_lat == 0) begin
            report_failure("keys_ready never rose after key_load");
        end else begin
            check_latency("keys_ready delay", ready_lat, KEY_DELAY);
        end
        if (offer) check_flag("out_valid after dropped block", seen_valid, 1'b0);
        close_test(row, start_errs);
    endtask

    task automatic run_single(input int row);
        int gap;
        int lat;
        int start_errs;
        start_errs = err_cnt;
        gap = $urandom % 4;            // Idle gap between blocks
        repeat (gap) next_cycle();
        in_valid = 1'b1;
        data_in  = vectors[row].pt;
        next_cycle();
        lat      = 1;
        in_valid = 1'b0;
        while (!out_valid && lat < PIPE_DELAY + 4) begin
            next_cycle();
            lat++;
        end
        if (!out_valid) begin
            report_failure($sformatf("no out_valid within %0d cycles of the block", lat));
        end else begin
            check_latency("out_valid delay", lat, PIPE_DELAY);
            check_block("data_out", data_out, vectors[row].ct);
        end
        next_cycle();
        check_flag("out_valid", out_valid, 1'b0);   // One-cycle strobe
        close_test(row, start_errs);
    endtask

    // Blocks go in on back-to-back cycles and must leave the same way
    task automatic run_burst(input int first, input int count);
        int lat;
        int start_errs;
        lat = 0;
        for (int k = 0; k < count; k++) begin
            in_valid = 1'b1;
            data_in  = vectors[first + k].pt;
            next_cycle();
            lat++;
        end
        in_valid = 1'b0;
        while (!out_valid && lat < PIPE_DELAY + count + 4) begin
            next_cycle();
            lat++;
        end
        for (int k = 0; k < count; k++) begin
            start_errs = err_cnt;
            if (k == 0) begin
                if (!out_valid) begin
                    report_failure($sformatf("no out_valid within %0d cycles of the burst", lat));
                end else begin
                    check_latency("burst out_valid delay", lat, PIPE_DELAY);
                end
            end else begin
                next_cycle();
                check_flag("out_valid", out_valid, 1'b1);
            end
            check_block("data_out", data_out, vectors[first + k].ct);
            if (k == count - 1) begin
                next_cycle();
                check_flag("out_valid", out_valid, 1'b0);
            end
            close_test(first + k, start_errs);
        end
    endtask

    initial begin
        int i;
        int j;
        int start_errs;
        void'($urandom(77));
        rst      = 1'b0;
        key_load = 1'b0;
        key_in   = '0;
        in_valid = 1'b0;
        data_in  = '0;

        // FIPS-197 C.1 and Appendix B, SP 800-38A ECB-AES128
        vectors[0] = '{LOAD_KEY, KEY_A, '0, '0};
        vectors[1] = '{SINGLE, KEY_A, 128'h00112233445566778899aabbccddeeff,
                       128'h69c4e0d86a7b0430d8cdb78070b4c55a};
        vectors[2] = '{DROPPED, KEY_B, 128'h00112233445566778899aabbccddeeff, '0};
        vectors[3] = '{SINGLE, KEY_B, 128'h3243f6a8885a308d313198a2e0370734,
                       128'h3925841d02dc09fbdc118597196a0b32};
        vectors[4] = '{SINGLE, KEY_B, 128'h6bc1bee22e409f96e93d7e117393172a,
                       128'h3ad77bb40d7a3660a89ecaf32466ef97};
        vectors[5] = '{BURST, KEY_B, 128'hae2d8a571e03ac9c9eb76fac45af8e51,
                       128'hf5d3d58503b9699de785895a96fdbaaf};
        vectors[6] = '{BURST, KEY_B, 128'h30c81c46a35ce411e5fbc1191a0a52ef,
                       128'h43b1cd7f598ece23881b00e3ed030688};
        vectors[7] = '{BURST, KEY_B, 128'hf69f2445df4f9b17ad2b417be66c3710,
                       128'h7b0c785e27e8ad3f8223207104725dd4};
        vectors[8] = '{LOAD_KEY, KEY_A, '0, '0};   // Back to the first key
        vectors[9] = '{SINGLE, KEY_A, 128'h00112233445566778899aabbccddeeff,
                       128'h69c4e0d86a7b0430d8cdb78070b4c55a};

        repeat (3) @(posedge clk);
        #2;
        rst = 1'b1;

        start_errs = err_cnt;
        check_flag("out_valid", out_valid, 1'b0);
        check_flag("keys_ready", keys_ready, 1'b0);
        if (err_cnt == start_errs) begin
            pass_cnt++;
            $display("Test reset passed");
        end else begin
            fail_cnt++;
            $display("Test reset failed");
        end

        i = 0;
        while (i < NUM_ROWS) begin
            case (vectors[i].mode)
                LOAD_KEY: begin
                    load_key(i, 1'b0);
                    i++;
                end
                DROPPED: begin
                    load_key(i, 1'b1);
                    i++;
                end
                SINGLE: begin
                    run_single(i);
                    i++;
                end
                default: begin
                    j = i;
                    while (j < NUM_ROWS && vectors[j].mode == BURST) j++;
                    run_burst(i, j - i);
                    i = j;
                end
            endcase
        end

        $display("Summary: %0d tests passed, %0d tests failed, %0d check errors",
                 pass_cnt, fail_cnt, err_cnt);
        if (err_cnt == 0 && fail_cnt == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* vlog.f */
source/aes_pkg.sv
source/round_key_if.sv
source/key_expander.sv
source/round_key_store.sv
source/cipher_round.sv
source/encrypt_pipeline.sv
source/aes_enc_top.sv
bench/aes_enc_tb.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide the result from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module aes_enc_tb -f vlog.f -o aes_enc_sim \
    && ./obj_dir/aes_enc_sim > sim.log 2>&1 \
    ; cat sim.log 2>/dev/null \
    ; grep -q "Simulation PASSED" sim.log \
    && echo "run_sim: pass" \
    || { echo "run_sim: fail"; exit 1; }
